// ==== memreq_pkg.sv ====
package memreq_pkg;

  localparam int ADDR_WIDTH = 28;
  localparam int ID_WIDTH = 4;
  localparam int LEN_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int BYTES_PER_BEAT = 4;
  localparam int FIFO_DEPTH = 16;  // Also caps the burst length at 15

  // Request and reply codes
  localparam logic [7:0] CMD_STORE = 8'h01;
  localparam logic [7:0] CMD_FETCH = 8'h80;
  localparam logic [7:0] CMD_WDONE = 8'h02;
  localparam logic [7:0] CMD_WFAIL = 8'h03;
  localparam logic [7:0] CMD_RDATA = 8'h81;
  localparam logic [7:0] CMD_RFAIL = 8'h82;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  typedef struct packed {
    logic                  is_read;
    logic [ID_WIDTH-1:0]   id;
    logic [LEN_WIDTH-1:0]  len;
    logic [ADDR_WIDTH-1:0] addr;
  } mem_cmd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } wr_beat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  okay;
    logic                  last;
  } rd_beat_t;

  typedef struct packed {
    logic                okay;
    logic [ID_WIDTH-1:0] id;
  } wr_status_t;

  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [ID_WIDTH-1:0]   id;
    logic [LEN_WIDTH-1:0]  len;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0]          resp;
    logic [ID_WIDTH-1:0] id;
  } axi_b_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
    logic [ID_WIDTH-1:0]   id;
  } axi_r_t;

endpackage

// ==== cmd_parser.sv ====
module cmd_parser (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  input  memreq_pkg::byte_beat_t s_byte_i,
  output logic                   cmd_valid_o,
  input  logic                   cmd_ready_i,
  output memreq_pkg::mem_cmd_t   cmd_o,
  output logic                   hdr_valid_o,
  input  logic                   hdr_ready_i,
  output memreq_pkg::mem_cmd_t   hdr_o,
  output logic                   d_valid_o,
  input  logic                   d_ready_i,
  output memreq_pkg::byte_beat_t d_byte_o,
  input  logic                   done_i
);

  typedef enum logic [1:0] {ST_HDR, ST_DATA, ST_WAIT} state_t;

  state_t               state_q;
  logic [5:0]           ptr_q;  // One-hot header byte pointer
  logic                 cmd_valid_q;
  logic                 hdr_valid_q;
  memreq_pkg::mem_cmd_t cmd_q;
  logic                 s_xfer;

  assign s_ready_o   = (state_q == ST_HDR) || (state_q == ST_DATA && d_ready_i);
  assign s_xfer      = s_valid_i && s_ready_o;
  assign cmd_valid_o = cmd_valid_q;
  assign hdr_valid_o = hdr_valid_q;
  assign cmd_o       = cmd_q;
  assign hdr_o       = cmd_q;
  assign d_valid_o   = (state_q == ST_DATA) && s_valid_i;
  assign d_byte_o    = s_byte_i;  // STORE payload passes straight through

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q     <= ST_HDR;
      ptr_q       <= 6'b000001;
      cmd_valid_q <= 1'b0;
      hdr_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_q && cmd_ready_i) cmd_valid_q <= 1'b0;
      if (hdr_valid_q && hdr_ready_i) hdr_valid_q <= 1'b0;
      case (state_q)
        ST_HDR: begin
          if (s_xfer) begin
            ptr_q <= {ptr_q[4:0], ptr_q[5]};
            if (ptr_q[5]) begin
              cmd_valid_q <= 1'b1;
              hdr_valid_q <= 1'b1;
              state_q     <= cmd_q.is_read ? ST_WAIT : ST_DATA;
            end
          end
        end
        ST_DATA: if (s_xfer && s_byte_i.last) state_q <= ST_WAIT;
        ST_WAIT: if (done_i) state_q <= ST_HDR;  // Reply has left
        default: state_q <= ST_HDR;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (state_q == ST_HDR && s_xfer) begin
      case (1'b1)
        ptr_q[0]: cmd_q.is_read <= s_byte_i.data[7];  // Bit 7 selects FETCH
        ptr_q[1]: cmd_q.len <= s_byte_i.data;
        ptr_q[2]: cmd_q.addr[7:0] <= s_byte_i.data;
        ptr_q[3]: cmd_q.addr[15:8] <= s_byte_i.data;
        ptr_q[4]: cmd_q.addr[23:16] <= s_byte_i.data;
        ptr_q[5]: {cmd_q.id, cmd_q.addr[27:24]} <= s_byte_i.data;
        default: ;
      endcase
    end
  end

endmodule

// ==== word_packer.sv ====
module word_packer (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   d_valid_i,
  output logic                   d_ready_o,
  input  memreq_pkg::byte_beat_t d_byte_i,
  output logic                   beat_valid_o,
  input  logic                   beat_ready_i,
  output memreq_pkg::wr_beat_t   beat_o
);

  logic [1:0]                      lane_q;
  logic [memreq_pkg::DATA_WIDTH-9:0] low_q;  // First three bytes of the word
  memreq_pkg::wr_beat_t            beat_q;
  logic                            beat_valid_q;
  logic                            top_lane;
  logic                            take;

  assign top_lane     = lane_q == 2'(memreq_pkg::BYTES_PER_BEAT - 1);
  assign d_ready_o    = !top_lane || !beat_valid_q || beat_ready_i;
  assign take         = d_valid_i && d_ready_o;
  assign beat_valid_o = beat_valid_q;
  assign beat_o       = beat_q;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      lane_q       <= '0;
      beat_valid_q <= 1'b0;
    end else begin
      if (beat_valid_q && beat_ready_i) beat_valid_q <= 1'b0;
      if (take) begin
        lane_q <= lane_q + 2'd1;
        if (top_lane) beat_valid_q <= 1'b1;
      end
    end
  end

  // Shift right so the first byte ends up in the low lane
  always_ff @(posedge bus_clock) begin
    if (take) begin
      if (top_lane) begin
        beat_q.data <= {d_byte_i.data, low_q};
        beat_q.last <= d_byte_i.last;
      end else begin
        low_q <= {d_byte_i.data, low_q[memreq_pkg::DATA_WIDTH-9:8]};
      end
    end
  end

endmodule

// ==== beat_fifo.sv ====
module beat_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = memreq_pkg::FIFO_DEPTH
) (
  input  logic     bus_clock,
  input  logic     bus_reset,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_o
);

  payload_t                   mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push;
  logic                       pop;

  assign in_ready_o  = count_q != DEPTH;
  assign out_valid_o = count_q != '0;
  assign out_o       = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (push) mem_q[wr_ptr_q] <= in_i;
  end

endmodule

// ==== axi_port.sv ====
module axi_port (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  memreq_pkg::mem_cmd_t   cmd_i,
  input  logic                   wb_valid_i,
  output logic                   wb_ready_o,
  input  memreq_pkg::wr_beat_t   wb_i,
  output logic                   awvalid_o,
  input  logic                   awready_i,
  output memreq_pkg::axi_aw_t    aw_o,
  output logic                   wvalid_o,
  input  logic                   wready_i,
  output memreq_pkg::axi_w_t     w_o,
  input  logic                   bvalid_i,
  output logic                   bready_o,
  input  memreq_pkg::axi_b_t     b_i,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  output memreq_pkg::axi_aw_t    ar_o,
  input  logic                   rvalid_i,
  output logic                   rready_o,
  input  memreq_pkg::axi_r_t     r_i,
  output logic                   ws_valid_o,
  input  logic                   ws_ready_i,
  output memreq_pkg::wr_status_t ws_o,
  output logic                   rb_valid_o,
  input  logic                   rb_ready_i,
  output memreq_pkg::rd_beat_t   rb_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP} state_t;

  state_t              state_q;
  logic                is_read_q;
  logic                awvalid_q;
  logic                arvalid_q;
  memreq_pkg::axi_aw_t addr_q;
  logic                wr_data;
  logic                rd_data;

  assign cmd_ready_o = state_q == ST_IDLE;
  assign wr_data     = (state_q == ST_DATA) && !is_read_q;
  assign rd_data     = (state_q == ST_DATA) && is_read_q;

  assign awvalid_o = awvalid_q;
  assign arvalid_o = arvalid_q;
  assign aw_o      = addr_q;
  assign ar_o      = addr_q;

  assign wvalid_o   = wr_data && wb_valid_i;
  assign wb_ready_o = wr_data && wready_i;
  assign w_o.data   = wb_i.data;
  assign w_o.last   = wb_i.last;

  // Write response goes straight on to the reply stage
  assign bready_o   = (state_q == ST_RESP) && ws_ready_i;
  assign ws_valid_o = (state_q == ST_RESP) && bvalid_i;
  assign ws_o.okay  = b_i.resp == memreq_pkg::RESP_OKAY;
  assign ws_o.id    = b_i.id;

  assign rready_o   = rd_data && rb_ready_i;
  assign rb_valid_o = rd_data && rvalid_i;
  assign rb_o.data  = r_i.data;
  assign rb_o.okay  = r_i.resp == memreq_pkg::RESP_OKAY;
  assign rb_o.last  = r_i.last;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q   <= ST_IDLE;
      awvalid_q <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            state_q   <= ST_ADDR;
            awvalid_q <= !cmd_i.is_read;
            arvalid_q <= cmd_i.is_read;
          end
        end
        ST_ADDR: begin
          if ((awvalid_q && awready_i) || (arvalid_q && arready_i)) begin
            state_q   <= ST_DATA;
            awvalid_q <= 1'b0;
            arvalid_q <= 1'b0;
          end
        end
        ST_DATA: begin
          if (wvalid_o && wready_i && wb_i.last) state_q <= ST_RESP;
          else if (rvalid_i && rready_o && r_i.last) state_q <= ST_IDLE;
        end
        ST_RESP: if (bvalid_i && bready_o) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (cmd_valid_i && cmd_ready_o) begin
      is_read_q   <= cmd_i.is_read;
      addr_q.addr <= cmd_i.addr;
      addr_q.id   <= cmd_i.id;
      addr_q.len  <= cmd_i.len;
    end
  end

endmodule

// ==== reply_builder.sv ====
module reply_builder (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   hdr_valid_i,
  output logic                   hdr_ready_o,
  input  memreq_pkg::mem_cmd_t   hdr_i,
  input  logic                   ws_valid_i,
  output logic                   ws_ready_o,
  input  memreq_pkg::wr_status_t ws_i,
  input  logic                   rb_valid_i,
  output logic                   rb_ready_o,
  input  memreq_pkg::rd_beat_t   rb_i,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  output memreq_pkg::byte_beat_t m_byte_o,
  output logic                   done_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_STAT, ST_CODE, ST_ID, ST_DATA} state_t;

  state_t                        state_q;
  logic [1:0]                    lane_q;
  logic                          is_read_q;
  logic [memreq_pkg::ID_WIDTH-1:0] id_q;
  logic [7:0]                    code_q;
  logic                          top_lane;
  logic                          xfer;

  assign top_lane    = lane_q == 2'(memreq_pkg::BYTES_PER_BEAT - 1);
  assign hdr_ready_o = state_q == ST_IDLE;
  assign ws_ready_o  = (state_q == ST_STAT) && !is_read_q;
  assign rb_ready_o  = (state_q == ST_DATA) && top_lane && m_ready_i;  // Pop after 4th byte
  assign m_valid_o   = (state_q == ST_CODE) || (state_q == ST_ID) ||
                       ((state_q == ST_DATA) && rb_valid_i);
  assign xfer        = m_valid_o && m_ready_i;
  assign done_o      = xfer && m_byte_o.last;

  always_comb begin
    m_byte_o = '0;
    case (state_q)
      ST_CODE: m_byte_o.data = code_q;
      ST_ID: begin
        m_byte_o.data = {{(8 - memreq_pkg::ID_WIDTH){1'b0}}, id_q};
        m_byte_o.last = !is_read_q;  // STORE reply ends here
      end
      ST_DATA: begin
        m_byte_o.data = rb_i.data[{lane_q, 3'b000} +: 8];
        m_byte_o.last = rb_i.last && top_lane;
      end
      default: ;
    endcase
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= ST_IDLE;
      lane_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (hdr_valid_i) state_q <= ST_STAT;
        ST_STAT: begin
          if ((!is_read_q && ws_valid_i) || (is_read_q && rb_valid_i)) state_q <= ST_CODE;
        end
        ST_CODE: if (xfer) state_q <= ST_ID;
        ST_ID: begin
          if (xfer) begin
            state_q <= is_read_q ? ST_DATA : ST_IDLE;
            lane_q  <= '0;
          end
        end
        ST_DATA: begin
          if (xfer) begin
            lane_q <= lane_q + 2'd1;
            if (m_byte_o.last) state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (state_q == ST_IDLE && hdr_valid_i) begin
      is_read_q <= hdr_i.is_read;
      id_q      <= hdr_i.id;
    end
    if (state_q == ST_STAT) begin
      if (!is_read_q && ws_valid_i) begin
        code_q <= ws_i.okay ? memreq_pkg::CMD_WDONE : memreq_pkg::CMD_WFAIL;
        id_q   <= ws_i.id;
      end else if (is_read_q && rb_valid_i) begin
        // Status peeked from the first read beat
        code_q <= rb_i.okay ? memreq_pkg::CMD_RDATA : memreq_pkg::CMD_RFAIL;
      end
    end
  end

endmodule

// ==== memreq_top.sv ====
module memreq_top (
  input  logic                   bus_clock,
  input  logic                   bus_reset,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  input  memreq_pkg::byte_beat_t s_byte_i,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  output memreq_pkg::byte_beat_t m_byte_o,
  output logic                   awvalid_o,
  input  logic                   awready_i,
  output memreq_pkg::axi_aw_t    aw_o,
  output logic                   wvalid_o,
  input  logic                   wready_i,
  output memreq_pkg::axi_w_t     w_o,
  input  logic                   bvalid_i,
  output logic                   bready_o,
  input  memreq_pkg::axi_b_t     b_i,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  output memreq_pkg::axi_aw_t    ar_o,
  input  logic                   rvalid_i,
  output logic                   rready_o,
  input  memreq_pkg::axi_r_t     r_i
);

  logic                   cmd_valid, cmd_ready;
  memreq_pkg::mem_cmd_t   cmd;
  logic                   hdr_valid, hdr_ready;
  memreq_pkg::mem_cmd_t   hdr;
  logic                   d_valid, d_ready;
  memreq_pkg::byte_beat_t d_byte;
  logic                   pk_valid, pk_ready;  // Packer into write FIFO
  memreq_pkg::wr_beat_t   pk_beat;
  logic                   wb_valid, wb_ready;
  memreq_pkg::wr_beat_t   wb;
  logic                   ws_valid, ws_ready;
  memreq_pkg::wr_status_t ws;
  logic                   rp_valid, rp_ready;  // Port into read FIFO
  memreq_pkg::rd_beat_t   rp_beat;
  logic                   rb_valid, rb_ready;
  memreq_pkg::rd_beat_t   rb;
  logic                   done;

  cmd_parser u_parser (
    .bus_clock, .bus_reset,
    .s_valid_i, .s_ready_o, .s_byte_i,
    .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_o(cmd),
    .hdr_valid_o(hdr_valid), .hdr_ready_i(hdr_ready), .hdr_o(hdr),
    .d_valid_o(d_valid), .d_ready_i(d_ready), .d_byte_o(d_byte),
    .done_i(done)
  );

  word_packer u_packer (
    .bus_clock, .bus_reset,
    .d_valid_i(d_valid), .d_ready_o(d_ready), .d_byte_i(d_byte),
    .beat_valid_o(pk_valid), .beat_ready_i(pk_ready), .beat_o(pk_beat)
  );

  beat_fifo #(
    .payload_t(memreq_pkg::wr_beat_t),
    .DEPTH    (memreq_pkg::FIFO_DEPTH)
  ) u_wr_fifo (
    .bus_clock, .bus_reset,
    .in_valid_i(pk_valid), .in_ready_o(pk_ready), .in_i(pk_beat),
    .out_valid_o(wb_valid), .out_ready_i(wb_ready), .out_o(wb)
  );

  axi_port u_port (
    .bus_clock, .bus_reset,
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_i(cmd),
    .wb_valid_i(wb_valid), .wb_ready_o(wb_ready), .wb_i(wb),
    .awvalid_o, .awready_i, .aw_o,
    .wvalid_o, .wready_i, .w_o,
    .bvalid_i, .bready_o, .b_i,
    .arvalid_o, .arready_i, .ar_o,
    .rvalid_i, .rready_o, .r_i,
    .ws_valid_o(ws_valid), .ws_ready_i(ws_ready), .ws_o(ws),
    .rb_valid_o(rp_valid), .rb_ready_i(rp_ready), .rb_o(rp_beat)
  );

  beat_fifo #(
    .payload_t(memreq_pkg::rd_beat_t),
    .DEPTH    (memreq_pkg::FIFO_DEPTH)
  ) u_rd_fifo (
    .bus_clock, .bus_reset,
    .in_valid_i(rp_valid), .in_ready_o(rp_ready), .in_i(rp_beat),
    .out_valid_o(rb_valid), .out_ready_i(rb_ready), .out_o(rb)
  );

  reply_builder u_reply (
    .bus_clock, .bus_reset,
    .hdr_valid_i(hdr_valid), .hdr_ready_o(hdr_ready), .hdr_i(hdr),
    .ws_valid_i(ws_valid), .ws_ready_o(ws_ready), .ws_i(ws),
    .rb_valid_i(rb_valid), .rb_ready_o(rb_ready), .rb_i(rb),
    .m_valid_o, .m_ready_i, .m_byte_o,
    .done_o(done)
  );

endmodule

// ==== tb_axi_mem.sv ====
module tb_axi_mem #(
  parameter int SEED = 1
) (
  input  logic                bus_clock,
  input  logic                bus_reset,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  memreq_pkg::axi_aw_t aw_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  memreq_pkg::axi_w_t  w_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output memreq_pkg::axi_b_t  b_o,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  memreq_pkg::axi_aw_t ar_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output memreq_pkg::axi_r_t  r_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [31:0]        words [1024];  // Word index is addr[11:2]
  int                 seed = SEED;
  logic               awready_q = 1'b0;
  logic               wready_q = 1'b0;
  logic               arready_q = 1'b0;
  logic               bvalid_q = 1'b0;
  logic               rvalid_q = 1'b0;
  memreq_pkg::axi_b_t b_q = '0;
  memreq_pkg::axi_r_t r_q = '0;
  logic [27:0]        wr_addr;
  logic [3:0]         wr_id;
  logic               wr_err;
  logic [27:0]        rd_addr;
  logic [3:0]         rd_id;
  logic               rd_err;
  int                 rd_left = 0;

  // Fill pattern over the full word index
  initial begin
    for (int i = 0; i < 1024; i++) words[i] = 32'h9e37_79b9 * (i + 1);
  end

  initial begin
    awready_o = 1'b0;
    wready_o  = 1'b0;
    arready_o = 1'b0;
    bvalid_o  = 1'b0;
    b_o       = '0;
    rvalid_o  = 1'b0;
    r_o       = '0;
  end

  // Responses reach the DUT 1 unit after the edge
  always @(posedge bus_clock) begin
    #1;
    awready_o = awready_q;
    wready_o  = wready_q;
    arready_o = arready_q;
    bvalid_o  = bvalid_q;
    b_o       = b_q;
    rvalid_o  = rvalid_q;
    r_o       = r_q;
  end

  always @(posedge bus_clock) begin
    if (bus_reset) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      rd_left   <= 0;
    end else begin
      // Each ready stalls about one cycle in four
      awready_q <= ($random(seed) & 3) != 0;
      wready_q  <= ($random(seed) & 3) != 0;
      arready_q <= ($random(seed) & 3) != 0;
      if (awvalid_i && awready_q) begin
        wr_addr <= aw_i.addr;
        wr_id   <= aw_i.id;
        wr_err  <= aw_i.addr[27];  // Upper half of the map is faulty
      end
      if (bvalid_q && bready_i) bvalid_q <= 1'b0;
      if (wvalid_i && wready_q) begin
        if (!wr_err) words[wr_addr[11:2]] <= w_i.data;
        wr_addr <= wr_addr + 28'd4;
        if (w_i.last) begin
          bvalid_q <= 1'b1;
          b_q.resp <= wr_err ? RESP_SLVERR : memreq_pkg::RESP_OKAY;
          b_q.id   <= wr_id;
        end
      end
      if (arvalid_i && arready_q) begin
        rd_addr <= ar_i.addr;
        rd_id   <= ar_i.id;
        rd_err  <= ar_i.addr[27];
        rd_left <= ar_i.len + 1;
      end else if ((!rvalid_q || rready_i) && rd_left != 0 && ($random(seed) & 3) != 0) begin
        rvalid_q   <= 1'b1;
        r_q.data   <= rd_err ? 32'h0 : words[rd_addr[11:2]];  // Error bursts read as zero
        r_q.resp   <= rd_err ? RESP_SLVERR : memreq_pkg::RESP_OKAY;
        r_q.last   <= rd_left == 1;
        r_q.id     <= rd_id;
        rd_addr    <= rd_addr + 28'd4;
        rd_left    <= rd_left - 1;
      end else if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

endmodule

// ==== tb_memreq.sv ====
module tb_memreq;

  localparam int SEED = 59865;
  localparam int NUM_TXN = 16;
  localparam int CYCLES_PER_TXN = 200;
  localparam int RESET_CYCLES = 4;

  logic                   bus_clock = 1'b0;
  logic                   bus_reset;
  logic                   s_valid;
  logic                   s_ready;
  memreq_pkg::byte_beat_t s_byte;
  logic                   m_valid;
  logic                   m_ready;
  memreq_pkg::byte_beat_t m_byte;
  logic                   awvalid, awready;
  memreq_pkg::axi_aw_t    aw;
  logic                   wvalid, wready;
  memreq_pkg::axi_w_t     w_beat;
  logic                   bvalid, bready;
  memreq_pkg::axi_b_t     b_resp;
  logic                   arvalid, arready;
  memreq_pkg::axi_aw_t    ar;
  logic                   rvalid, rready;
  memreq_pkg::axi_r_t     r_beat;

  int                     seed = SEED;
  int                     stall_seed = SEED;  // Reply back-pressure only
  memreq_pkg::byte_beat_t exp_q[$];   // Expected reply bytes
  memreq_pkg::mem_cmd_t   addr_q[$];  // Expected AW and AR requests
  memreq_pkg::byte_beat_t exp_head;
  memreq_pkg::mem_cmd_t   addr_head;
  int                     exp_cnt;
  int                     addr_cnt;
  logic [31:0]            shadow [1024];

  memreq_top dut0 (
    .bus_clock, .bus_reset,
    .s_valid_i(s_valid), .s_ready_o(s_ready), .s_byte_i(s_byte),
    .m_valid_o(m_valid), .m_ready_i(m_ready), .m_byte_o(m_byte),
    .awvalid_o(awvalid), .awready_i(awready), .aw_o(aw),
    .wvalid_o(wvalid), .wready_i(wready), .w_o(w_beat),
    .bvalid_i(bvalid), .bready_o(bready), .b_i(b_resp),
    .arvalid_o(arvalid), .arready_i(arready), .ar_o(ar),
    .rvalid_i(rvalid), .rready_o(rready), .r_i(r_beat)
  );

  tb_axi_mem #(.SEED(SEED)) mem0 (
    .bus_clock, .bus_reset,
    .awvalid_i(awvalid), .awready_o(awready), .aw_i(aw),
    .wvalid_i(wvalid), .wready_o(wready), .w_i(w_beat),
    .bvalid_o(bvalid), .bready_i(bready), .b_o(b_resp),
    .arvalid_i(arvalid), .arready_o(arready), .ar_i(ar),
    .rvalid_o(rvalid), .rready_i(rready), .r_o(r_beat)
  );

  always #5 bus_clock = ~bus_clock;

  task automatic end_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    end_with_failure();
  endtask

  function automatic void refresh_heads();
    exp_cnt   = exp_q.size();
    addr_cnt  = addr_q.size();
    exp_head  = (exp_cnt != 0) ? exp_q[0] : '0;
    addr_head = (addr_cnt != 0) ? addr_q[0] : '0;
  endfunction

  function automatic void expect_byte(input logic [7:0] data, input logic last);
    memreq_pkg::byte_beat_t eb;
    eb.data = data;
    eb.last = last;
    exp_q.push_back(eb);
  endfunction

  function automatic void expect_request(input logic is_read, input logic [3:0] id,
                                         input int len, input logic [27:0] addr);
    memreq_pkg::mem_cmd_t req;
    req.is_read = is_read;
    req.id      = id;
    req.len     = 8'(len);
    req.addr    = addr;
    addr_q.push_back(req);
  endfunction

  // Entered and left 1 unit after a rising edge
  task automatic send_byte(input logic [7:0] data, input logic last);
    int gap;
    gap = (($random(seed) & 3) == 0) ? ($random(seed) & 3) + 1 : 0;
    repeat (gap) begin
      @(posedge bus_clock);
      #1;
    end
    s_valid = 1'b1;
    s_byte.data = data;
    s_byte.last = last;
    do begin
      @(posedge bus_clock);
    end while (!s_ready);
    #1;
    s_valid = 1'b0;
  endtask

  task automatic send_header(input logic [7:0] code, input int len, input logic [27:0] addr,
                             input logic [3:0] id, input logic last);
    send_byte(code, 1'b0);
    send_byte(8'(len), 1'b0);
    send_byte(addr[7:0], 1'b0);
    send_byte(addr[15:8], 1'b0);
    send_byte(addr[23:16], 1'b0);
    send_byte({id, addr[27:24]}, last);
  endtask

  task automatic run_store(input logic [27:0] addr, input logic [3:0] id, input int len);
    logic [31:0] word;
    logic        fail;
    fail = addr[27];
    expect_request(1'b0, id, len, addr);
    expect_byte(fail ? memreq_pkg::CMD_WFAIL : memreq_pkg::CMD_WDONE, 1'b0);
    expect_byte({4'h0, id}, 1'b1);
    refresh_heads();
    send_header(memreq_pkg::CMD_STORE, len, addr, id, 1'b0);
    for (int i = 0; i <= len; i++) begin
      word = $random(seed);
      if (!fail) shadow[10'(addr[11:2] + i)] = word;
      for (int b = 0; b < 4; b++) send_byte(word[8*b +: 8], (i == len) && (b == 3));
    end
  endtask

  task automatic run_fetch(input logic [27:0] addr, input logic [3:0] id, input int len);
    logic [31:0] word;
    logic        fail;
    fail = addr[27];
    expect_request(1'b1, id, len, addr);
    expect_byte(fail ? memreq_pkg::CMD_RFAIL : memreq_pkg::CMD_RDATA, 1'b0);
    expect_byte({4'h0, id}, 1'b0);
    for (int i = 0; i <= len; i++) begin
      word = fail ? 32'h0 : shadow[10'(addr[11:2] + i)];
      for (int b = 0; b < 4; b++) expect_byte(word[8*b +: 8], (i == len) && (b == 3));
    end
    refresh_heads();
    send_header(memreq_pkg::CMD_FETCH, len, addr, id, 1'b1);
  endtask

  // Random back-pressure on the reply stream
  always @(posedge bus_clock) begin
    #1;
    m_ready = ($random(stall_seed) & 3) != 0;
  end

  // Scoreboard pops on each handshake
  always @(posedge bus_clock) begin
    if (!bus_reset) begin
      if (m_valid && m_ready && exp_q.size() != 0) void'(exp_q.pop_front());
      if (((awvalid && awready) || (arvalid && arready)) && addr_q.size() != 0) begin
        void'(addr_q.pop_front());
      end
      refresh_heads();
    end
  end

  reset_quiet: assert property (@(negedge bus_clock)
      (bus_reset || $past(bus_reset)) |->
      !(m_valid || awvalid || wvalid || arvalid || bready || rready))
    else report_mismatch("valid or ready output high during or right after reset");

  reply_byte: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (m_valid && m_ready) |-> (exp_cnt != 0 && m_byte == exp_head))
    else report_mismatch($sformatf("reply byte %h last %b, expected %h last %b",
                                   $sampled(m_byte.data), $sampled(m_byte.last),
                                   $sampled(exp_head.data), $sampled(exp_head.last)));

  aw_request: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (awvalid && awready) |->
      (addr_cnt != 0 && !addr_head.is_read &&
       aw == {addr_head.addr, addr_head.id, addr_head.len}))
    else report_mismatch($sformatf("AW request %h does not match the frame", $sampled(aw)));

  ar_request: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (arvalid && arready) |->
      (addr_cnt != 0 && addr_head.is_read &&
       ar == {addr_head.addr, addr_head.id, addr_head.len}))
    else report_mismatch($sformatf("AR request %h does not match the frame", $sampled(ar)));

  m_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_byte)))
    else report_mismatch("reply byte changed before its handshake");

  aw_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (awvalid && !awready) |=> (awvalid && $stable(aw)))
    else report_mismatch("AW changed before its handshake");

  w_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (wvalid && !wready) |=> (wvalid && $stable(w_beat)))
    else report_mismatch("W beat changed before its handshake");

  ar_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
      (arvalid && !arready) |=> (arvalid && $stable(ar)))
    else report_mismatch("AR changed before its handshake");

  initial begin
    repeat (RESET_CYCLES + CYCLES_PER_TXN * NUM_TXN) @(posedge bus_clock);
    $display("Timeout: the run hung and did not finish in time");
    end_with_failure();
  end

  initial begin
    logic [27:0] addr;
    int          len;
    bus_reset = 1'b1;
    s_valid   = 1'b0;
    s_byte    = '0;
    m_ready   = 1'b0;
    refresh_heads();
    repeat (RESET_CYCLES) @(posedge bus_clock);
    #1;
    bus_reset = 1'b0;

    // Directed lengths 0, 3 and 15, then the faulty window
    run_store(28'h35a1040, 4'($random(seed)), 0);
    run_fetch(28'h35a1040, 4'($random(seed)), 0);
    run_store(28'h35a1100, 4'($random(seed)), 3);
    run_fetch(28'h35a1100, 4'($random(seed)), 3);
    run_store(28'h35a1200, 4'($random(seed)), 15);
    run_fetch(28'h35a1200, 4'($random(seed)), 15);
    run_store(28'hb5a1300, 4'($random(seed)), 2);
    run_fetch(28'hb5a1300, 4'($random(seed)), 2);
    repeat (4) begin
      len  = $random(seed) & 15;
      addr = 28'h35a1000 + 28'(($random(seed) & 255) * 4);
      run_store(addr, 4'($random(seed)), len);
      run_fetch(addr, 4'($random(seed)), len);
    end

    wait (exp_cnt == 0 && addr_cnt == 0);
    repeat (4) @(posedge bus_clock);
    if (s_ready && !m_valid) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("The bridge did not return to idle after the last reply");
      end_with_failure();
    end
  end

endmodule

// ==== src.f ====
memreq_pkg.sv
cmd_parser.sv
word_packer.sv
beat_fifo.sv
axi_port.sv
reply_builder.sv
memreq_top.sv
tb_axi_mem.sv
tb_memreq.sv

// ==== Bender.yml ====
package:
  name: memreq_bridge

sources:
  - memreq_pkg.sv
  - cmd_parser.sv
  - word_packer.sv
  - beat_fifo.sv
  - axi_port.sv
  - reply_builder.sv
  - memreq_top.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_memreq.sv
